// File: isa_pkg.sv
package isa_pkg;

  // Branch conditions as produced by the decoder
  // The gt, ge, lt and le conditions compare A against zero as a signed value
  typedef enum logic [2:0] {
    cond_uncond = 3'd0,
    cond_eq     = 3'd1,
    cond_ne     = 3'd2,
    cond_gt     = 3'd3,
    cond_ge     = 3'd4,
    cond_lt     = 3'd5,
    cond_le     = 3'd6
  } branch_cond_t;

  // Execution class selects which unit may take the instruction
  typedef enum logic [2:0] {
    class_alu    = 3'd0,
    class_muldiv = 3'd1,
    class_load   = 3'd2,
    class_store  = 3'd3,
    class_branch = 3'd4,
    class_jump   = 3'd5
  } exec_class_t;

  // One decoded instruction as it leaves the instruction queue
  typedef struct packed {
    logic [31:0]  pc;
    exec_class_t  exec_class;
    logic [4:0]   a_reg;
    logic         a_reg_valid;
    logic [4:0]   b_reg;
    logic         b_reg_valid;
    logic [4:0]   dest_reg;
    logic         dest_reg_valid;
    // Set for register jumps, where the target comes from operand A
    logic         rformat;
    branch_cond_t branch_cond;
    logic [31:0]  branch_target;
    logic [31:0]  imm;
  } dec_inst_t;

endpackage

// File: pipe_pkg.sv
package pipe_pkg;

  // Number of queue entries looked at in each cycle
  localparam int issue_width = 4;

  // Two register-file read ports per queue entry, A then B
  localparam int rf_ports = 8;

  // Record written back to the reorder buffer by the branch unit
  typedef struct packed {
    // Link value, which is the branch pc plus 8
    logic [31:0] result;
    logic [4:0]  dest_reg;
    logic        dest_reg_valid;
    // High when the branch or jump redirects fetch
    logic        redirect;
  } rob_write_t;

endpackage

// File: issue_if.sv
`timescale 1ns/1ns

// One dispatch port from the issue selector to an execution unit
// An instruction moves in every cycle where valid is high
interface issue_if
  import isa_pkg::*;
#(
  parameter int rob_depth_log2 = 4
);

  logic [rob_depth_log2-1:0] rob_slot;
  logic [31:0]               a;
  logic [31:0]               b;
  dec_inst_t                 inst;
  logic                      valid;
  logic                      ready;

  modport issuer (
    output rob_slot, a, b, inst, valid,
    input  ready
  );

  modport unit (
    input  rob_slot, a, b, inst, valid,
    output ready
  );

endinterface

// File: operand_resolve.sv
`timescale 1ns/1ns

module operand_resolve
  import isa_pkg::*;
  import pipe_pkg::*;
(
  input  dec_inst_t   insns [issue_width],

  // Reorder-buffer associative lookup
  output logic [4:0]  as_areg [issue_width],
  output logic [4:0]  as_breg [issue_width],
  input  logic [31:0] as_aval [issue_width],
  input  logic [31:0] as_bval [issue_width],
  input  logic        as_aval_valid [issue_width],
  input  logic        as_bval_valid [issue_width],
  input  logic        as_aval_present [issue_width],
  input  logic        as_bval_present [issue_width],

  // Register file read ports
  output logic [4:0]  rd_addr [rf_ports],
  input  logic [31:0] rd_data [rf_ports],

  output logic [31:0] op_a [issue_width],
  output logic [31:0] op_b [issue_width],
  output logic        ops_ready [issue_width]
);

  for (genvar i = 0; i < issue_width; i++) begin : g_slot
    logic a_ok;
    logic b_ok;

    assign as_areg[i] = insns[i].a_reg;
    assign as_breg[i] = insns[i].b_reg;

    // Slot i owns read ports 2i for A and 2i+1 for B
    assign rd_addr[2*i]   = insns[i].a_reg;
    assign rd_addr[2*i+1] = insns[i].b_reg;

    // A register still in flight is held by the reorder buffer
    assign op_a[i] = as_aval_present[i] ? as_aval[i] : rd_data[2*i];
    assign op_b[i] = as_bval_present[i] ? as_bval[i] : rd_data[2*i+1];

    // An absent register is current in the register file
    assign a_ok = ~as_aval_present[i] | as_aval_valid[i];
    assign b_ok = ~as_bval_present[i] | as_bval_valid[i];

    // Operands the instruction does not read never hold it back
    assign ops_ready[i] = (a_ok | ~insns[i].a_reg_valid) &
                          (b_ok | ~insns[i].b_reg_valid);
  end

endmodule

// File: issue_select.sv
`timescale 1ns/1ns

module issue_select
  import isa_pkg::*;
  import pipe_pkg::*;
#(
  parameter int rob_depth_log2 = 4
) (
  // Instruction queue side
  input  logic                      ext_valid [issue_width],
  input  dec_inst_t                 insns [issue_width],
  input  logic [rob_depth_log2-1:0] insn_rob_slot [issue_width],
  output logic                      ext_enable,
  output logic [1:0]                ext_consumed,

  // Resolved operands per slot
  input  logic [31:0]               op_a [issue_width],
  input  logic [31:0]               op_b [issue_width],
  input  logic                      ops_ready [issue_width],

  issue_if.issuer                   branch_port,
  issue_if.issuer                   ls_port,
  issue_if.issuer                   ex_port,
  issue_if.issuer                   mul_port
);

  localparam int idx_w = $clog2(issue_width);

  logic             br_used;
  logic             ls_used;
  logic             ex_used;
  logic             mul_used;
  logic [idx_w-1:0] br_idx;
  logic [idx_w-1:0] ls_idx;
  logic [idx_w-1:0] ex_idx;
  logic [idx_w-1:0] mul_idx;
  logic [2:0]       consumed;
  logic             next_valid [issue_width];

  // A branch needs its delay slot in the same cycle, so the last slot never has one
  always_comb begin
    for (int i = 0; i < issue_width - 1; i++) begin
      next_valid[i] = ext_valid[i+1];
    end
    next_valid[issue_width-1] = 1'b0;
  end

  // Strictly in-order scan, each unit taking at most one instruction
  always_comb begin
    logic        blocked;
    exec_class_t cls;

    blocked  = 1'b0;
    consumed = '0;
    br_used  = 1'b0;
    ls_used  = 1'b0;
    ex_used  = 1'b0;
    mul_used = 1'b0;
    br_idx   = '0;
    ls_idx   = '0;
    ex_idx   = '0;
    mul_idx  = '0;

    for (int i = 0; i < issue_width; i++) begin
      cls = insns[i].exec_class;
      if (!blocked) begin
        if (!ext_valid[i] || !ops_ready[i]) begin
          blocked = 1'b1;
        end else if ((cls == class_branch || cls == class_jump) && !br_used &&
                     branch_port.ready && next_valid[i]) begin
          br_used  = 1'b1;
          br_idx   = idx_w'(i);
          consumed = consumed + 3'd1;
        end else if ((cls == class_load || cls == class_store) && !ls_used &&
                     ls_port.ready) begin
          ls_used  = 1'b1;
          ls_idx   = idx_w'(i);
          consumed = consumed + 3'd1;
        end else if (cls == class_muldiv && !mul_used && mul_port.ready) begin
          mul_used = 1'b1;
          mul_idx  = idx_w'(i);
          consumed = consumed + 3'd1;
        end else if (cls == class_alu && !ex_used && ex_port.ready) begin
          ex_used  = 1'b1;
          ex_idx   = idx_w'(i);
          consumed = consumed + 3'd1;
        end else if (cls == class_alu && !mul_used && mul_port.ready) begin
          // The multiply/divide unit also executes plain ALU work
          mul_used = 1'b1;
          mul_idx  = idx_w'(i);
          consumed = consumed + 3'd1;
        end else begin
          // No unit free for this one, so every later slot waits as well
          blocked = 1'b1;
        end
      end
    end
  end

  // The queue expects the count minus one
  assign ext_enable   = (consumed != 3'd0);
  assign ext_consumed = 2'(consumed - 3'd1);

  assign branch_port.valid    = br_used;
  assign branch_port.inst     = insns[br_idx];
  assign branch_port.a        = op_a[br_idx];
  assign branch_port.b        = op_b[br_idx];
  assign branch_port.rob_slot = insn_rob_slot[br_idx];

  assign ls_port.valid    = ls_used;
  assign ls_port.inst     = insns[ls_idx];
  assign ls_port.a        = op_a[ls_idx];
  assign ls_port.b        = op_b[ls_idx];
  assign ls_port.rob_slot = insn_rob_slot[ls_idx];

  assign ex_port.valid    = ex_used;
  assign ex_port.inst     = insns[ex_idx];
  assign ex_port.a        = op_a[ex_idx];
  assign ex_port.b        = op_b[ex_idx];
  assign ex_port.rob_slot = insn_rob_slot[ex_idx];

  assign mul_port.valid    = mul_used;
  assign mul_port.inst     = insns[mul_idx];
  assign mul_port.a        = op_a[mul_idx];
  assign mul_port.b        = op_b[mul_idx];
  assign mul_port.rob_slot = insn_rob_slot[mul_idx];

endmodule

// File: branch_resolve.sv
`timescale 1ns/1ns

module branch_resolve
  import isa_pkg::*;
  import pipe_pkg::*;
#(
  parameter int rob_depth_log2 = 4
) (
  input  logic                      clock,
  input  logic                      reset_n,

  issue_if.unit                     branch_port,

  // Fetch side
  input  logic                      branch_stall,
  output logic [31:0]               new_pc,
  output logic                      new_pc_valid,

  // Link write into the reorder buffer
  output logic [rob_depth_log2-1:0] wr_slot,
  output logic                      wr_valid,
  output rob_write_t                wr_data
);

  logic                      stall_d1;
  logic                      ret_valid;
  dec_inst_t                 ret_inst;
  logic [31:0]               ret_a;
  logic [31:0]               ret_b;
  logic [rob_depth_log2-1:0] ret_slot;

  logic                      act_valid;
  dec_inst_t                 act_inst;
  logic [31:0]               act_a;
  logic [31:0]               act_b;
  logic                      a_eq_b;
  logic                      a_eqz;
  logic                      a_gez;
  logic                      a_gtz;
  logic                      cond_ok;

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      stall_d1  <= 1'b0;
      ret_valid <= 1'b0;
    end else begin
      stall_d1 <= branch_stall;
      if (branch_stall && !stall_d1) begin
        ret_valid <= branch_port.valid;
      end
    end
  end

  // Keep the branch that was in flight when fetch began to stall
  always_ff @(posedge clock) begin
    if (branch_stall && !stall_d1) begin
      ret_inst <= branch_port.inst;
      ret_a    <= branch_port.a;
      ret_b    <= branch_port.b;
      ret_slot <= branch_port.rob_slot;
    end
  end

  // No new branch in the cycle after a stall cycle
  assign branch_port.ready = ~stall_d1;

  assign act_valid = stall_d1 ? ret_valid : branch_port.valid;
  assign act_inst  = stall_d1 ? ret_inst  : branch_port.inst;
  assign act_a     = stall_d1 ? ret_a     : branch_port.a;
  assign act_b     = stall_d1 ? ret_b     : branch_port.b;
  assign wr_slot   = stall_d1 ? ret_slot  : branch_port.rob_slot;

  // Comparisons against zero treat A as signed
  assign a_eq_b = (act_a == act_b);
  assign a_eqz  = (act_a == 32'd0);
  assign a_gez  = ~act_a[31];
  assign a_gtz  = a_gez & ~a_eqz;

  always_comb begin
    case (act_inst.branch_cond)
      cond_uncond: cond_ok = 1'b1;
      cond_eq:     cond_ok = a_eq_b;
      cond_ne:     cond_ok = ~a_eq_b;
      cond_gt:     cond_ok = a_gtz;
      cond_ge:     cond_ok = a_gez;
      cond_lt:     cond_ok = ~a_gez;
      cond_le:     cond_ok = ~a_gtz;
      default:     cond_ok = 1'b0;
    endcase
  end

  assign new_pc_valid = act_valid &
                        ((act_inst.exec_class == class_jump) |
                         ((act_inst.exec_class == class_branch) & cond_ok));
  assign new_pc       = act_inst.rformat ? act_a : act_inst.branch_target;

  // The link value skips the delay slot
  assign wr_valid               = act_valid & ~branch_stall;
  assign wr_data.result         = act_inst.pc + 32'd8;
  assign wr_data.dest_reg       = act_inst.dest_reg;
  assign wr_data.dest_reg_valid = act_inst.dest_reg_valid;
  assign wr_data.redirect       = new_pc_valid;

endmodule

// File: issue_stage.sv
`timescale 1ns/1ns

module issue_stage
  import isa_pkg::*;
  import pipe_pkg::*;
#(
  parameter int rob_depth_log2 = 4
) (
  input  logic                      clock,
  input  logic                      reset_n,

  // Instruction queue
  input  logic                      ext_valid [issue_width],
  input  dec_inst_t                 insns [issue_width],
  input  logic [rob_depth_log2-1:0] insn_rob_slot [issue_width],
  output logic                      ext_enable,
  output logic [1:0]                ext_consumed,

  // Reorder buffer lookup and write
  output logic [rob_depth_log2-1:0] as_query_idx [issue_width],
  output logic [4:0]                as_areg [issue_width],
  output logic [4:0]                as_breg [issue_width],
  input  logic [31:0]               as_aval [issue_width],
  input  logic [31:0]               as_bval [issue_width],
  input  logic                      as_aval_valid [issue_width],
  input  logic                      as_bval_valid [issue_width],
  input  logic                      as_aval_present [issue_width],
  input  logic                      as_bval_present [issue_width],
  output logic [rob_depth_log2-1:0] wr_slot,
  output logic                      wr_valid,
  output rob_write_t                wr_data,

  // Register file
  output logic [4:0]                rd_addr [rf_ports],
  input  logic [31:0]               rd_data [rf_ports],

  // Fetch
  input  logic                      branch_stall,
  output logic [31:0]               new_pc,
  output logic                      new_pc_valid,

  // Load/store unit
  output logic [rob_depth_log2-1:0] ls_rob_slot,
  output logic [31:0]               ls_a,
  output logic [31:0]               ls_b,
  output dec_inst_t                 ls_inst,
  output logic                      ls_valid,
  input  logic                      ls_ready,

  // ALU
  output logic [rob_depth_log2-1:0] ex_rob_slot,
  output logic [31:0]               ex_a,
  output logic [31:0]               ex_b,
  output dec_inst_t                 ex_inst,
  output logic                      ex_valid,
  input  logic                      ex_ready,

  // Multiply/divide unit
  output logic [rob_depth_log2-1:0] mul_rob_slot,
  output logic [31:0]               mul_a,
  output logic [31:0]               mul_b,
  output dec_inst_t                 mul_inst,
  output logic                      mul_valid,
  input  logic                      mul_ready
);

  logic [31:0] op_a [issue_width];
  logic [31:0] op_b [issue_width];
  logic        ops_ready [issue_width];

  issue_if #(.rob_depth_log2(rob_depth_log2)) branch_port ();
  issue_if #(.rob_depth_log2(rob_depth_log2)) ls_port ();
  issue_if #(.rob_depth_log2(rob_depth_log2)) ex_port ();
  issue_if #(.rob_depth_log2(rob_depth_log2)) mul_port ();

  // Each slot looks itself up in the reorder buffer by its own slot number
  assign as_query_idx = insn_rob_slot;

  operand_resolve i_operand_resolve (
    .insns           (insns),
    .as_areg         (as_areg),
    .as_breg         (as_breg),
    .as_aval         (as_aval),
    .as_bval         (as_bval),
    .as_aval_valid   (as_aval_valid),
    .as_bval_valid   (as_bval_valid),
    .as_aval_present (as_aval_present),
    .as_bval_present (as_bval_present),
    .rd_addr         (rd_addr),
    .rd_data         (rd_data),
    .op_a            (op_a),
    .op_b            (op_b),
    .ops_ready       (ops_ready)
  );

  issue_select #(.rob_depth_log2(rob_depth_log2)) i_issue_select (
    .ext_valid     (ext_valid),
    .insns         (insns),
    .insn_rob_slot (insn_rob_slot),
    .ext_enable    (ext_enable),
    .ext_consumed  (ext_consumed),
    .op_a          (op_a),
    .op_b          (op_b),
    .ops_ready     (ops_ready),
    .branch_port   (branch_port.issuer),
    .ls_port       (ls_port.issuer),
    .ex_port       (ex_port.issuer),
    .mul_port      (mul_port.issuer)
  );

  branch_resolve #(.rob_depth_log2(rob_depth_log2)) i_branch_resolve (
    .clock        (clock),
    .reset_n      (reset_n),
    .branch_port  (branch_port.unit),
    .branch_stall (branch_stall),
    .new_pc       (new_pc),
    .new_pc_valid (new_pc_valid),
    .wr_slot      (wr_slot),
    .wr_valid     (wr_valid),
    .wr_data      (wr_data)
  );

  // The three external units are reached through plain pins
  assign ls_rob_slot   = ls_port.rob_slot;
  assign ls_a          = ls_port.a;
  assign ls_b          = ls_port.b;
  assign ls_inst       = ls_port.inst;
  assign ls_valid      = ls_port.valid;
  assign ls_port.ready = ls_ready;

  assign ex_rob_slot   = ex_port.rob_slot;
  assign ex_a          = ex_port.a;
  assign ex_b          = ex_port.b;
  assign ex_inst       = ex_port.inst;
  assign ex_valid      = ex_port.valid;
  assign ex_port.ready = ex_ready;

  assign mul_rob_slot   = mul_port.rob_slot;
  assign mul_a          = mul_port.a;
  assign mul_b          = mul_port.b;
  assign mul_inst       = mul_port.inst;
  assign mul_valid      = mul_port.valid;
  assign mul_port.ready = mul_ready;

endmodule

// File: tb_issue_stage.sv
`timescale 1ns/1ns

module tb_issue_stage
  import isa_pkg::*;
  import pipe_pkg::*;
();

  localparam int rob_depth_log2 = 4;
  localparam int num_tests      = 2000;
  localparam int reset_cycles   = 8;
  localparam int idle_cycles    = 2;
  localparam int cycle_limit    = reset_cycles + idle_cycles + num_tests + 20;

  // Unit numbering used by the reference model
  localparam int unit_br  = 0;
  localparam int unit_ls  = 1;
  localparam int unit_ex  = 2;
  localparam int unit_mul = 3;

  logic                      clock = 1'b0;
  logic                      reset_n;
  logic                      ext_valid [issue_width];
  dec_inst_t                 insns [issue_width];
  logic [rob_depth_log2-1:0] insn_rob_slot [issue_width];
  logic                      ext_enable;
  logic [1:0]                ext_consumed;
  logic [rob_depth_log2-1:0] as_query_idx [issue_width];
  logic [4:0]                as_areg [issue_width];
  logic [4:0]                as_breg [issue_width];
  logic [31:0]               as_aval [issue_width];
  logic [31:0]               as_bval [issue_width];
  logic                      as_aval_valid [issue_width];
  logic                      as_bval_valid [issue_width];
  logic                      as_aval_present [issue_width];
  logic                      as_bval_present [issue_width];
  logic [rob_depth_log2-1:0] wr_slot;
  logic                      wr_valid;
  rob_write_t                wr_data;
  logic [4:0]                rd_addr [rf_ports];
  logic [31:0]               rd_data [rf_ports];
  logic                      branch_stall;
  logic [31:0]               new_pc;
  logic                      new_pc_valid;
  logic [rob_depth_log2-1:0] ls_rob_slot;
  logic [31:0]               ls_a;
  logic [31:0]               ls_b;
  dec_inst_t                 ls_inst;
  logic                      ls_valid;
  logic                      ls_ready;
  logic [rob_depth_log2-1:0] ex_rob_slot;
  logic [31:0]               ex_a;
  logic [31:0]               ex_b;
  dec_inst_t                 ex_inst;
  logic                      ex_valid;
  logic                      ex_ready;
  logic [rob_depth_log2-1:0] mul_rob_slot;
  logic [31:0]               mul_a;
  logic [31:0]               mul_b;
  dec_inst_t                 mul_inst;
  logic                      mul_valid;
  logic                      mul_ready;

  // Reference model state that mirrors the delayed stall and the held branch
  logic                      stall_d1_m;
  logic                      ret_valid_m;
  dec_inst_t                 ret_inst_m;
  logic [31:0]               ret_a_m;
  logic [31:0]               ret_b_m;
  logic [rob_depth_log2-1:0] ret_slot_m;

  // Reference model results for the current cycle
  logic [31:0]               m_a [issue_width];
  logic [31:0]               m_b [issue_width];
  logic                      m_rdy [issue_width];
  logic                      m_valid [4];
  int                        m_idx [4];
  int                        m_consumed;
  logic                      m_act_valid;
  logic [rob_depth_log2-1:0] m_wr_slot;
  logic                      m_new_pc_valid;
  logic [31:0]               m_new_pc;
  logic                      m_wr_valid;
  rob_write_t                m_wr_data;

  int stall_left;
  int cycle_count = 0;
  int checks_done = 0;
  int value_errors = 0;
  int rule_errors = 0;

  issue_stage #(.rob_depth_log2(rob_depth_log2)) i_issue_stage (.*);

  always #50 clock = ~clock;

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout: run did not finish within %0d cycles", cycle_limit);
      $display("sim failed");
      $finish;
    end
  end

  task automatic compare_value(input string name, input logic [159:0] expected,
                               input logic [159:0] actual);
    checks_done++;
    if (actual !== expected) begin
      value_errors++;
      $display("FAIL %s expected %0h actual %0h", name, expected, actual);
    end
  endtask

  // Zero, small and small negative values make eq and sign tests hit often
  function automatic logic [31:0] pick_operand();
    case ($urandom % 4)
      0:       return 32'd0;
      1:       return 32'($urandom % 3);
      2:       return 32'hffff_fffd + 32'($urandom % 3);
      default: return $urandom;
    endcase
  endfunction

  function automatic dec_inst_t random_inst();
    dec_inst_t inst;
    inst.pc             = $urandom & 32'hffff_fffc;
    inst.exec_class     = exec_class_t'(3'($urandom % 6));
    inst.a_reg          = 5'($urandom);
    inst.a_reg_valid    = ($urandom % 4) != 0;
    inst.b_reg          = 5'($urandom);
    inst.b_reg_valid    = ($urandom % 4) != 0;
    inst.dest_reg       = 5'($urandom);
    inst.dest_reg_valid = ($urandom % 2) != 0;
    inst.rformat        = ($urandom % 4) == 0;
    inst.branch_cond    = branch_cond_t'(3'($urandom % 7));
    inst.branch_target  = $urandom & 32'hffff_fffc;
    inst.imm            = $urandom;
    return inst;
  endfunction

  function automatic logic cond_holds(input branch_cond_t cond, input logic [31:0] a,
                                      input logic [31:0] b);
    case (cond)
      cond_uncond: return 1'b1;
      cond_eq:     return a == b;
      cond_ne:     return a != b;
      cond_gt:     return $signed(a) > 0;
      cond_ge:     return $signed(a) >= 0;
      cond_lt:     return $signed(a) < 0;
      cond_le:     return $signed(a) <= 0;
      default:     return 1'b0;
    endcase
  endfunction

  task automatic clear_inputs();
    for (int i = 0; i < issue_width; i++) begin
      ext_valid[i]       = 1'b0;
      insns[i]           = '0;
      insn_rob_slot[i]   = '0;
      as_aval[i]         = '0;
      as_bval[i]         = '0;
      as_aval_valid[i]   = 1'b0;
      as_bval_valid[i]   = 1'b0;
      as_aval_present[i] = 1'b0;
      as_bval_present[i] = 1'b0;
    end
    for (int p = 0; p < rf_ports; p++) begin
      rd_data[p] = '0;
    end
    branch_stall = 1'b0;
    ls_ready     = 1'b1;
    ex_ready     = 1'b1;
    mul_ready    = 1'b1;
  endtask

  task automatic drive_random();
    int n;
    n = $urandom % 5;
    for (int i = 0; i < issue_width; i++) begin
      ext_valid[i]       = (i < n);
      insns[i]           = random_inst();
      insn_rob_slot[i]   = rob_depth_log2'($urandom);
      as_aval[i]         = pick_operand();
      as_bval[i]         = pick_operand();
      as_aval_present[i] = ($urandom % 2) != 0;
      as_bval_present[i] = ($urandom % 2) != 0;
      as_aval_valid[i]   = ($urandom % 4) != 0;
      as_bval_valid[i]   = ($urandom % 4) != 0;
    end
    for (int p = 0; p < rf_ports; p++) begin
      rd_data[p] = pick_operand();
    end
    ls_ready  = ($urandom % 4) != 0;
    ex_ready  = ($urandom % 4) != 0;
    mul_ready = ($urandom % 4) != 0;
    // Fetch stalls come in short bursts of one to four cycles
    if (stall_left > 0) begin
      branch_stall = 1'b1;
      stall_left--;
    end else if (($urandom % 8) == 0) begin
      branch_stall = 1'b1;
      stall_left   = $urandom % 4;
    end else begin
      branch_stall = 1'b0;
    end
  endtask

  task automatic compute_model();
    logic        blocked;
    logic        delay_ok;
    exec_class_t cls;
    int          unit;
    logic        act_valid;
    dec_inst_t   act_inst;
    logic [31:0] act_a;
    logic [31:0] act_b;

    for (int i = 0; i < issue_width; i++) begin
      m_a[i]   = as_aval_present[i] ? as_aval[i] : rd_data[2*i];
      m_b[i]   = as_bval_present[i] ? as_bval[i] : rd_data[2*i+1];
      m_rdy[i] = (!insns[i].a_reg_valid || !as_aval_present[i] || as_aval_valid[i]) &&
                 (!insns[i].b_reg_valid || !as_bval_present[i] || as_bval_valid[i]);
    end

    for (int u = 0; u < 4; u++) begin
      m_valid[u] = 1'b0;
      m_idx[u]   = 0;
    end
    m_consumed = 0;
    blocked    = 1'b0;
    for (int i = 0; i < issue_width; i++) begin
      if (!blocked) begin
        cls      = insns[i].exec_class;
        unit     = -1;
        delay_ok = 1'b0;
        if (i < issue_width - 1) begin
          delay_ok = ext_valid[i+1];
        end
        if (ext_valid[i] && m_rdy[i]) begin
          case (cls)
            class_branch, class_jump: begin
              if (!m_valid[unit_br] && !stall_d1_m && delay_ok) unit = unit_br;
            end
            class_load, class_store: begin
              if (!m_valid[unit_ls] && ls_ready) unit = unit_ls;
            end
            class_muldiv: begin
              if (!m_valid[unit_mul] && mul_ready) unit = unit_mul;
            end
            class_alu: begin
              if (!m_valid[unit_ex] && ex_ready) unit = unit_ex;
              else if (!m_valid[unit_mul] && mul_ready) unit = unit_mul;
            end
            default: unit = -1;
          endcase
        end
        if (unit < 0) begin
          blocked = 1'b1;
        end else begin
          m_valid[unit] = 1'b1;
          m_idx[unit]   = i;
          m_consumed++;
        end
      end
    end

    // After a stall cycle the branch unit works on the held copy
    if (stall_d1_m) begin
      act_valid = ret_valid_m;
      act_inst  = ret_inst_m;
      act_a     = ret_a_m;
      act_b     = ret_b_m;
      m_wr_slot = ret_slot_m;
    end else begin
      act_valid = m_valid[unit_br];
      act_inst  = insns[m_idx[unit_br]];
      act_a     = m_a[m_idx[unit_br]];
      act_b     = m_b[m_idx[unit_br]];
      m_wr_slot = insn_rob_slot[m_idx[unit_br]];
    end
    m_act_valid    = act_valid;
    m_new_pc_valid = act_valid && (act_inst.exec_class == class_jump ||
                     (act_inst.exec_class == class_branch &&
                      cond_holds(act_inst.branch_cond, act_a, act_b)));
    m_new_pc       = act_inst.rformat ? act_a : act_inst.branch_target;
    m_wr_valid     = act_valid && !branch_stall;
    m_wr_data.result         = act_inst.pc + 32'd8;
    m_wr_data.dest_reg       = act_inst.dest_reg;
    m_wr_data.dest_reg_valid = act_inst.dest_reg_valid;
    m_wr_data.redirect       = m_new_pc_valid;
  endtask

  // Mirrors what the DUT registers at the coming rising edge
  task automatic update_model_state();
    if (branch_stall && !stall_d1_m) begin
      ret_valid_m = m_valid[unit_br];
      ret_inst_m  = insns[m_idx[unit_br]];
      ret_a_m     = m_a[m_idx[unit_br]];
      ret_b_m     = m_b[m_idx[unit_br]];
      ret_slot_m  = insn_rob_slot[m_idx[unit_br]];
    end
    stall_d1_m = branch_stall;
  endtask

  task automatic check_unit(input string name, input int unit, input logic valid,
                            input dec_inst_t inst, input logic [31:0] a,
                            input logic [31:0] b, input logic [rob_depth_log2-1:0] slot,
                            input logic ready);
    int k;
    k = m_idx[unit];
    compare_value($sformatf("routing %s_valid", name), m_valid[unit], valid);
    if (valid && !ready) begin
      rule_errors++;
      $display("The %s unit received an instruction while its ready was low", name);
    end
    if (m_valid[unit]) begin
      compare_value($sformatf("routing %s_inst", name), insns[k], inst);
      compare_value($sformatf("operands %s_a", name), m_a[k], a);
      compare_value($sformatf("operands %s_b", name), m_b[k], b);
      compare_value($sformatf("routing %s_rob_slot", name), insn_rob_slot[k], slot);
    end
  endtask

  task automatic check_outputs();
    compare_value("routing ext_enable", m_consumed != 0, ext_enable);
    if (m_consumed != 0) begin
      compare_value("routing ext_consumed", m_consumed - 1, ext_consumed);
    end
    for (int i = 0; i < issue_width; i++) begin
      compare_value($sformatf("operands as_query_idx[%0d]", i), insn_rob_slot[i],
                    as_query_idx[i]);
      compare_value($sformatf("operands as_areg[%0d]", i), insns[i].a_reg, as_areg[i]);
      compare_value($sformatf("operands as_breg[%0d]", i), insns[i].b_reg, as_breg[i]);
      compare_value($sformatf("operands rd_addr[%0d]", 2*i), insns[i].a_reg, rd_addr[2*i]);
      compare_value($sformatf("operands rd_addr[%0d]", 2*i+1), insns[i].b_reg,
                    rd_addr[2*i+1]);
    end
    check_unit("ls", unit_ls, ls_valid, ls_inst, ls_a, ls_b, ls_rob_slot, ls_ready);
    check_unit("ex", unit_ex, ex_valid, ex_inst, ex_a, ex_b, ex_rob_slot, ex_ready);
    check_unit("mul", unit_mul, mul_valid, mul_inst, mul_a, mul_b, mul_rob_slot, mul_ready);
    compare_value("branch new_pc_valid", m_new_pc_valid, new_pc_valid);
    if (m_new_pc_valid) begin
      compare_value("branch new_pc", m_new_pc, new_pc);
    end
    compare_value("branch wr_valid", m_wr_valid, wr_valid);
    if (m_act_valid) begin
      compare_value("branch wr_slot", m_wr_slot, wr_slot);
      compare_value("branch wr_data", m_wr_data, wr_data);
    end
    if (wr_valid && branch_stall) begin
      rule_errors++;
      $display("Link write to the reorder buffer happened while fetch was stalled");
    end
  endtask

  task automatic check_idle(input string name);
    compare_value({name, " ext_enable"}, 1'b0, ext_enable);
    compare_value({name, " ls_valid"}, 1'b0, ls_valid);
    compare_value({name, " ex_valid"}, 1'b0, ex_valid);
    compare_value({name, " mul_valid"}, 1'b0, mul_valid);
    compare_value({name, " new_pc_valid"}, 1'b0, new_pc_valid);
    compare_value({name, " wr_valid"}, 1'b0, wr_valid);
  endtask

  initial begin
    void'($urandom(32160));
    reset_n     = 1'b0;
    stall_d1_m  = 1'b0;
    ret_valid_m = 1'b0;
    stall_left  = 0;
    clear_inputs();

    // Outputs are checked 10 ns ahead of each rising edge
    // The first reset check follows the first rising edge
    @(negedge clock);
    repeat (reset_cycles - 1) begin
      #40;
      check_idle("reset");
      @(negedge clock);
    end
    reset_n = 1'b1;
    repeat (idle_cycles) begin
      #40;
      check_idle("idle after reset");
      @(negedge clock);
    end

    for (int t = 0; t < num_tests; t++) begin
      drive_random();
      #40;
      compute_model();
      check_outputs();
      update_model_state();
      @(negedge clock);
    end

    $display("Checks run: %0d, value errors: %0d, rule errors: %0d",
             checks_done, value_errors, rule_errors);
    if (value_errors == 0 && rule_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: list.f
isa_pkg.sv
pipe_pkg.sv
issue_if.sv
operand_resolve.sv
issue_select.sv
branch_resolve.sv
issue_stage.sv
tb_issue_stage.sv

// File: Bender.yml
package:
  name: issue_stage

sources:
  - files:
      - isa_pkg.sv
      - pipe_pkg.sv
      - issue_if.sv
      - operand_resolve.sv
      - issue_select.sv
      - branch_resolve.sv
      - issue_stage.sv
  - target: test
    files:
      - tb_issue_stage.sv
